// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_decoding_graph
FLIST     = flist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+source
source/decoder_pkg.sv
source/edge_weight_regs.sv
source/neighbor_link.sv
source/processing_unit.sv
source/cluster_parity.sv
source/decoding_graph.sv
verification/decoding_graph_props.sv
verification/decoding_graph_checker.sv
verification/tb_decoding_graph.sv

// ==== source/cluster_parity.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module cluster_parity
    import decoder_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  pu_view_t [`PU_COUNT-1:0]        views_i,
    input  logic     [`PU_COUNT-1:0]        defects_i,
    input  logic     [`PU_COUNT-1:0]        changed_i,
    output logic     [`PU_COUNT-1:0]        odd_o,
    output logic                            busy_o
);

    logic [`PU_COUNT-1:0] parity;
    logic [`PU_COUNT-1:0] boundary;
    logic [`PU_COUNT-1:0] odd_q;
    logic                 changed_any;
    logic                 changed_q;

    // every unit sums over all units sharing its root
    always_comb begin
        for (int i = 0; i < `PU_COUNT; i++) begin
            parity[i]   = 1'b0;
            boundary[i] = 1'b0;
            for (int j = 0; j < `PU_COUNT; j++) begin
                if (views_i[j].root == views_i[i].root) begin
                    parity[i]   = parity[i] ^ defects_i[j];
                    boundary[i] = boundary[i] | views_i[j].touches_boundary;
                end
            end
        end
    end

    assign changed_any = |changed_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            odd_q     <= '0;
            changed_q <= 1'b0;
        end else begin
            odd_q     <= parity & ~boundary;  // boundary contact makes a cluster even
            changed_q <= changed_any;
        end
    end

    assign odd_o  = odd_q;
    // held one more cycle so the odd register catches up
    assign busy_o = changed_any | changed_q;

endmodule

// ==== source/decoder_consts.svh ====
`ifndef DECODER_CONSTS_SVH
`define DECODER_CONSTS_SVH

// planar grid, rows by columns
`define GRID_X 4
`define GRID_Z 4
`define PU_COUNT 16
`define ADDR_W 4

// link weights
`define WEIGHT_W 2
`define DEFAULT_WEIGHT 2

// 12 north-south, 12 east-west, 4 west boundary, 4 east boundary
`define LINK_COUNT 32
`define LINK_ADDR_W 5

// neighbour slot order inside a unit
`define DIR_NORTH 0
`define DIR_SOUTH 1
`define DIR_WEST 2
`define DIR_EAST 3

`endif

// ==== source/decoder_pkg.sv ====
package decoder_pkg;

`include "decoder_consts.svh"

    // stage levels driven from outside
    typedef enum logic [2:0] {
        stage_idle  = 3'd0,
        stage_load  = 3'd1,
        stage_grow  = 3'd2,
        stage_merge = 3'd3
    } stage_e;

    // row * GRID_Z + column
    typedef logic [`ADDR_W-1:0] pu_addr_t;

    // one-cycle write strobe into the weight block
    typedef struct packed {
        logic                   valid;
        logic [`LINK_ADDR_W-1:0] link;
        logic [`WEIGHT_W-1:0]    weight;
    } weight_wr_t;

    // what a link shows to the units on either side
    typedef struct packed {
        logic                fully_grown;
        logic                is_boundary;
        logic [`WEIGHT_W-1:0] grown;  // growth so far
        logic                spare;
    } link_view_t;

    // what a unit shows to its neighbours
    typedef struct packed {
        pu_addr_t root;
        logic     touches_boundary;
        logic     odd;
    } pu_view_t;

endpackage

// ==== source/decoding_graph.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module decoding_graph
    import decoder_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  stage_e                     global_stage_i,
    input  logic       [`PU_COUNT-1:0] measurements_i,
    input  weight_wr_t                 weight_wr_i,
    output pu_addr_t   [`PU_COUNT-1:0] roots_o,
    output logic       [`PU_COUNT-1:0] odd_clusters_o,
    output logic                       busy_o
);

    // link index bases
    localparam int EW_BASE = (`GRID_X - 1) * `GRID_Z;
    localparam int WB_BASE = EW_BASE + `GRID_X * (`GRID_Z - 1);
    localparam int EB_BASE = WB_BASE + `GRID_X;

    logic [`LINK_COUNT-1:0][`WEIGHT_W-1:0] weights;
    link_view_t [`LINK_COUNT-1:0]          link_view;
    pu_view_t   [`PU_COUNT-1:0]            pu_view;
    link_view_t [3:0]                      unit_links [`PU_COUNT];
    pu_view_t   [3:0]                      unit_nbrs  [`PU_COUNT];
    logic       [`PU_COUNT-1:0]            defects;
    logic       [`PU_COUNT-1:0]            changed;
    logic       [`PU_COUNT-1:0]            odd_flags;

    edge_weight_regs u_weights (
        .clk         (clk),
        .reset       (reset),
        .weight_wr_i (weight_wr_i),
        .weights_o   (weights)
    );

    for (genvar r = 0; r < `GRID_X; r++) begin : g_row
        for (genvar c = 0; c < `GRID_Z; c++) begin : g_col
            localparam int IDX = r * `GRID_Z + c;

            if (r < `GRID_X - 1) begin : g_ns  // link to the unit below
                neighbor_link #(.IS_BOUNDARY(1'b0)) u_link (
                    .clk(clk), .reset(reset), .global_stage_i(global_stage_i),
                    .weight_i(weights[IDX]), .a_odd_i(pu_view[IDX].odd),
                    .b_odd_i(pu_view[IDX + `GRID_Z].odd), .view_o(link_view[IDX])
                );
            end
            if (c < `GRID_Z - 1) begin : g_ew  // link to the unit on the right
                localparam int L = EW_BASE + r * (`GRID_Z - 1) + c;
                neighbor_link #(.IS_BOUNDARY(1'b0)) u_link (
                    .clk(clk), .reset(reset), .global_stage_i(global_stage_i),
                    .weight_i(weights[L]), .a_odd_i(pu_view[IDX].odd),
                    .b_odd_i(pu_view[IDX + 1].odd), .view_o(link_view[L])
                );
            end
            if (c == 0 || c == `GRID_Z - 1) begin : g_bnd
                localparam int L = (c == 0) ? WB_BASE + r : EB_BASE + r;
                neighbor_link #(.IS_BOUNDARY(1'b1)) u_link (
                    .clk(clk), .reset(reset), .global_stage_i(global_stage_i),
                    .weight_i(weights[L]), .a_odd_i(pu_view[IDX].odd),
                    .b_odd_i(1'b0), .view_o(link_view[L])
                );
            end

            if (r > 0) begin : g_n
                assign unit_links[IDX][`DIR_NORTH] = link_view[IDX - `GRID_Z];
                assign unit_nbrs[IDX][`DIR_NORTH]  = pu_view[IDX - `GRID_Z];
            end else begin : g_n_none
                assign unit_links[IDX][`DIR_NORTH] = '0;
                assign unit_nbrs[IDX][`DIR_NORTH]  = '0;
            end
            if (r < `GRID_X - 1) begin : g_s
                assign unit_links[IDX][`DIR_SOUTH] = link_view[IDX];
                assign unit_nbrs[IDX][`DIR_SOUTH]  = pu_view[IDX + `GRID_Z];
            end else begin : g_s_none
                assign unit_links[IDX][`DIR_SOUTH] = '0;
                assign unit_nbrs[IDX][`DIR_SOUTH]  = '0;
            end
            if (c > 0) begin : g_w
                assign unit_links[IDX][`DIR_WEST] = link_view[EW_BASE + r * (`GRID_Z - 1) + c - 1];
                assign unit_nbrs[IDX][`DIR_WEST]  = pu_view[IDX - 1];
            end else begin : g_w_bnd
                assign unit_links[IDX][`DIR_WEST] = link_view[WB_BASE + r];
                assign unit_nbrs[IDX][`DIR_WEST]  = '0;  // nothing behind a boundary
            end
            if (c < `GRID_Z - 1) begin : g_e
                assign unit_links[IDX][`DIR_EAST] = link_view[EW_BASE + r * (`GRID_Z - 1) + c];
                assign unit_nbrs[IDX][`DIR_EAST]  = pu_view[IDX + 1];
            end else begin : g_e_bnd
                assign unit_links[IDX][`DIR_EAST] = link_view[EB_BASE + r];
                assign unit_nbrs[IDX][`DIR_EAST]  = '0;
            end

            processing_unit u_pu (
                .clk(clk), .reset(reset), .global_stage_i(global_stage_i),
                .measurement_i(measurements_i[IDX]), .own_addr_i(pu_addr_t'(IDX)),
                .links_i(unit_links[IDX]), .neighbors_i(unit_nbrs[IDX]),
                .odd_i(odd_flags[IDX]), .defect_o(defects[IDX]),
                .view_o(pu_view[IDX]), .changed_o(changed[IDX])
            );
            assign roots_o[IDX] = pu_view[IDX].root;
        end
    end

    cluster_parity u_parity (
        .clk       (clk),
        .reset     (reset),
        .views_i   (pu_view),
        .defects_i (defects),
        .changed_i (changed),
        .odd_o     (odd_flags),
        .busy_o    (busy_o)
    );

    assign odd_clusters_o = odd_flags;

endmodule

// ==== source/edge_weight_regs.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module edge_weight_regs
    import decoder_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  weight_wr_t                              weight_wr_i,
    output logic [`LINK_COUNT-1:0][`WEIGHT_W-1:0]   weights_o
);

    logic [`LINK_COUNT-1:0][`WEIGHT_W-1:0] weights;

    // one register per link, every link starts at the default weight
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < `LINK_COUNT; l++) begin
                weights[l] <= `WEIGHT_W'(`DEFAULT_WEIGHT);
            end
        end else if (weight_wr_i.valid) begin
            weights[weight_wr_i.link] <= weight_wr_i.weight;  // addressed write
        end
    end

    assign weights_o = weights;  // seen by the link one cycle after the strobe

endmodule

// ==== source/neighbor_link.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module neighbor_link
    import decoder_pkg::*;
#(
    parameter bit IS_BOUNDARY = 1'b0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  stage_e               global_stage_i,
    input  logic [`WEIGHT_W-1:0] weight_i,
    input  logic                 a_odd_i,
    input  logic                 b_odd_i,  // tied low on a boundary link
    output link_view_t           view_o
);

    localparam int SUM_W = `WEIGHT_W + 1;

    logic [`WEIGHT_W-1:0] growth;
    logic [SUM_W-1:0]     grow_sum;
    logic                 fully_grown;

    // each odd endpoint pushes the link one step
    assign grow_sum = SUM_W'(growth) + SUM_W'(a_odd_i) + SUM_W'(b_odd_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else begin
            case (global_stage_i)
                stage_load: begin
                    growth <= '0;
                end
                stage_grow: begin
                    if (grow_sum >= SUM_W'(weight_i)) begin
                        growth <= weight_i;  // saturate at the weight
                    end else begin
                        growth <= grow_sum[`WEIGHT_W-1:0];
                    end
                end
                default: begin
                    growth <= growth;
                end
            endcase
        end
    end

    // weight 0 counts as grown from the start
    assign fully_grown = (growth >= weight_i);

    assign view_o.fully_grown = fully_grown;
    assign view_o.is_boundary = IS_BOUNDARY;
    assign view_o.grown       = growth;
    assign view_o.spare       = 1'b0;

endmodule

// ==== source/processing_unit.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module processing_unit
    import decoder_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  stage_e               global_stage_i,
    input  logic                 measurement_i,
    input  pu_addr_t             own_addr_i,
    input  link_view_t [3:0]     links_i,      // north, south, west, east
    input  pu_view_t   [3:0]     neighbors_i,
    input  logic                 odd_i,
    output logic                 defect_o,
    output pu_view_t             view_o,
    output logic                 changed_o
);

    pu_addr_t root;
    pu_addr_t root_next;
    logic     defect;
    logic     defect_next;
    logic     touches_boundary;
    logic     touches_next;

    always_comb begin
        root_next    = root;
        defect_next  = defect;
        touches_next = touches_boundary;
        case (global_stage_i)
            stage_load: begin
                defect_next  = measurement_i;
                root_next    = own_addr_i;  // every unit is its own cluster
                touches_next = 1'b0;
            end
            stage_merge: begin
                for (int d = 0; d < 4; d++) begin
                    if (links_i[d].fully_grown) begin
                        if (links_i[d].is_boundary) begin
                            touches_next = 1'b1;
                        end else begin
                            // flood the smallest root across grown links
                            if (neighbors_i[d].root < root_next) begin
                                root_next = neighbors_i[d].root;
                            end
                            touches_next = touches_next | neighbors_i[d].touches_boundary;
                        end
                    end
                end
            end
            default: begin
                root_next = root;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root             <= own_addr_i;
            defect           <= 1'b0;
            touches_boundary <= 1'b0;
        end else begin
            root             <= root_next;
            defect           <= defect_next;
            touches_boundary <= touches_next;
        end
    end

    // state moves at the next edge
    assign changed_o = (root_next != root) || (defect_next != defect) ||
                       (touches_next != touches_boundary);

    assign defect_o                = defect;
    assign view_o.root             = root;
    assign view_o.touches_boundary = touches_boundary;
    assign view_o.odd              = odd_i;  // from the parity block

endmodule

// ==== verification/decoding_graph_checker.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module decoding_graph_checker
    import decoder_pkg::*;
#(
    parameter int MAX_BUSY = 40
) (
    input  logic                       clk,
    input  logic                       reset,
    input  stage_e                     stage_i,
    input  logic                       busy_i,
    input  pu_addr_t   [`PU_COUNT-1:0] roots_i,
    input  logic       [`PU_COUNT-1:0] odd_i,
    input  pu_addr_t   [`PU_COUNT-1:0] exp_roots_i,
    input  logic       [`PU_COUNT-1:0] exp_odd_i,
    output int                         error_count_o,
    output int                         check_count_o
);

    int   errors = 0;
    int   checks = 0;
    int   busy_cycles = 0;
    logic settled = 1'b0;  // one compare per merge

    always @(posedge clk) begin
        if (reset || stage_i != stage_merge) begin
            busy_cycles = 0;
            settled = 1'b0;
        end else if (busy_i) begin
            busy_cycles++;
            if (busy_cycles == MAX_BUSY) begin
                $display("ERROR at %0t: merge did not settle, busy_o high for %0d cycles",
                         $time, busy_cycles);
                errors++;
            end
        end else if (!settled) begin
            settled = 1'b1;  // first cycle with busy_o low
            for (int i = 0; i < `PU_COUNT; i++) begin
                checks++;
                if (roots_i[i] !== exp_roots_i[i]) begin
                    $display("MISMATCH at %0t: roots_o[%0d] dut=%0d exp=%0d",
                             $time, i, roots_i[i], exp_roots_i[i]);
                    errors++;
                end
                checks++;
                if (odd_i[i] !== exp_odd_i[i]) begin
                    $display("MISMATCH at %0t: odd_clusters_o[%0d] dut=%b exp=%b",
                             $time, i, odd_i[i], exp_odd_i[i]);
                    errors++;
                end
            end
        end
    end

    assign error_count_o = errors;
    assign check_count_o = checks;

endmodule

// ==== verification/decoding_graph_props.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module decoding_graph_props
    import decoder_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  stage_e                     global_stage_i,
    input  weight_wr_t                 weight_wr_i,
    input  pu_addr_t   [`PU_COUNT-1:0] roots_o,
    input  logic                       busy_o
);

    int fail_count = 0;  // failed assertions so far

    // nothing has moved yet in the first cycle out of reset
    a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy_o)
        else begin
            $error("busy_o high in the first cycle after reset");
            fail_count++;
        end

    // roots only ever flood downward from the unit's own address
    for (genvar i = 0; i < `PU_COUNT; i++) begin : g_root
        a_root_bound: assert property (@(posedge clk) disable iff (reset)
            roots_o[i] <= pu_addr_t'(i))
            else begin
                $error("root of unit %0d above its own address", i);
                fail_count++;
            end
    end

    // weights may only change between trials
    a_write_in_idle: assert property (@(posedge clk) disable iff (reset)
        weight_wr_i.valid |-> global_stage_i == stage_idle)
        else begin
            $error("weight write outside the idle stage");
            fail_count++;
        end

endmodule

// ==== verification/tb_decoding_graph.sv ====
`timescale 1ns/1ps

`include "decoder_consts.svh"

module tb_decoding_graph
    import decoder_pkg::*;
;

    localparam int NUM_TRIALS = 24;
    localparam int MAX_ROUNDS = 8;
    localparam int MAX_BUSY   = 40;
    localparam int RESET_CYCLES = 8;

    logic                       clk = 1'b0;
    logic                       reset;
    stage_e                     stage;
    logic       [`PU_COUNT-1:0] meas;
    weight_wr_t                 wr;
    pu_addr_t   [`PU_COUNT-1:0] roots;
    logic       [`PU_COUNT-1:0] odd_clusters;
    logic                       busy;

    // reference state
    logic       [`WEIGHT_W-1:0] ref_weight [`LINK_COUNT];
    logic       [`WEIGHT_W-1:0] ref_growth [`LINK_COUNT];
    logic       [`PU_COUNT-1:0] ref_defect;
    pu_addr_t   [`PU_COUNT-1:0] exp_roots;
    logic       [`PU_COUNT-1:0] exp_odd;
    logic       [31:0]          lfsr_state = 32'hdf2e_79d5;
    int                         error_count;
    int                         check_count;

    always #4 clk = ~clk;

    decoding_graph u_decoding_graph (
        .clk(clk), .reset(reset), .global_stage_i(stage), .measurements_i(meas),
        .weight_wr_i(wr), .roots_o(roots), .odd_clusters_o(odd_clusters), .busy_o(busy)
    );

    decoding_graph_checker #(.MAX_BUSY(MAX_BUSY)) u_checker (
        .clk(clk), .reset(reset), .stage_i(stage), .busy_i(busy), .roots_i(roots),
        .odd_i(odd_clusters), .exp_roots_i(exp_roots), .exp_odd_i(exp_odd),
        .error_count_o(error_count), .check_count_o(check_count)
    );

    bind decoding_graph decoding_graph_props u_props (
        .clk(clk), .reset(reset), .global_stage_i(global_stage_i),
        .weight_wr_i(weight_wr_i), .roots_o(roots_o), .busy_o(busy_o)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // endpoints: north-south, east-west, west boundary, east boundary
    function automatic int link_a(input int l);
        if (l < 12) return l;
        if (l < 24) return ((l - 12) / 3) * `GRID_Z + (l - 12) % 3;
        if (l < 28) return (l - 24) * `GRID_Z;
        return (l - 28) * `GRID_Z + `GRID_Z - 1;
    endfunction

    function automatic int link_b(input int l);
        if (l < 12) return l + `GRID_Z;
        if (l < 24) return link_a(l) + 1;
        return -1;  // boundary
    endfunction

    // components over grown links, min address as root
    function automatic void compute_ref();
        int   lbl [`PU_COUNT];
        logic par [`PU_COUNT];
        logic bnd [`PU_COUNT];
        bit   moved;
        int   a;
        int   b;
        for (int i = 0; i < `PU_COUNT; i++) begin
            lbl[i] = i;
            par[i] = 1'b0;
            bnd[i] = 1'b0;
        end
        do begin
            moved = 0;
            for (int l = 0; l < 24; l++) begin
                a = link_a(l);
                b = link_b(l);
                if (ref_growth[l] >= ref_weight[l] && lbl[a] != lbl[b]) begin
                    lbl[a] = (lbl[a] < lbl[b]) ? lbl[a] : lbl[b];
                    lbl[b] = lbl[a];
                    moved = 1;
                end
            end
        end while (moved);
        for (int l = 24; l < `LINK_COUNT; l++) begin
            if (ref_growth[l] >= ref_weight[l]) bnd[lbl[link_a(l)]] = 1'b1;
        end
        for (int i = 0; i < `PU_COUNT; i++) par[lbl[i]] = par[lbl[i]] ^ ref_defect[i];
        for (int i = 0; i < `PU_COUNT; i++) begin
            exp_roots[i] = pu_addr_t'(lbl[i]);
            exp_odd[i]   = par[lbl[i]] & ~bnd[lbl[i]];
        end
    endfunction

    // one grow step driven by the current odd flags
    function automatic void grow_ref();
        int sum;
        int b;
        for (int l = 0; l < `LINK_COUNT; l++) begin
            b = link_b(l);
            sum = int'(ref_growth[l]) + int'(exp_odd[link_a(l)]);
            if (b >= 0) sum = sum + int'(exp_odd[b]);
            if (sum >= int'(ref_weight[l])) ref_growth[l] = ref_weight[l];
            else ref_growth[l] = `WEIGHT_W'(sum);
        end
    endfunction

    task automatic set_all_weights(input logic [`WEIGHT_W-1:0] w);
        for (int l = 0; l < `LINK_COUNT; l++) ref_weight[l] = w;
    endtask

    task automatic merge_until_idle();
        int cycles;
        cycles = 0;
        stage = stage_merge;
        do begin
            @(posedge clk);
            cycles++;
        end while (busy && cycles < MAX_BUSY);
        #1;
    endtask

    task automatic run_trial(input logic [`PU_COUNT-1:0] defects);
        int rounds;
        stage = stage_idle;
        for (int l = 0; l < `LINK_COUNT; l++) begin
            wr.valid  = 1'b1;
            wr.link   = `LINK_ADDR_W'(l);
            wr.weight = ref_weight[l];
            @(posedge clk);
            #1;
        end
        wr.valid = 1'b0;
        stage = stage_load;
        meas = defects;
        ref_defect = defects;
        for (int l = 0; l < `LINK_COUNT; l++) ref_growth[l] = '0;
        compute_ref();
        @(posedge clk);
        #1;
        merge_until_idle();
        rounds = 0;
        while (rounds < MAX_ROUNDS && exp_odd != '0) begin
            stage = stage_grow;
            grow_ref();
            compute_ref();
            @(posedge clk);
            #1;
            merge_until_idle();
            rounds++;
        end
        stage = stage_idle;
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0] v;
        reset = 1'b1;
        stage = stage_idle;
        meas  = '0;
        wr    = '0;
        exp_odd = '0;
        for (int i = 0; i < `PU_COUNT; i++) exp_roots[i] = pu_addr_t'(i);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        set_all_weights(`WEIGHT_W'(`DEFAULT_WEIGHT));  // random defects on default weights
        draw_bits(`PU_COUNT, v);
        run_trial(v[`PU_COUNT-1:0]);

        set_all_weights(2'd2);  // two neighbours 5 and 6 on a light link
        ref_weight[16] = 2'd1;
        run_trial(16'h0060);

        set_all_weights(2'd2);  // unit 4 beside a light west boundary
        ref_weight[25] = 2'd1;
        run_trial(16'h0010);

        set_all_weights(2'd3);  // heavy links, single-sided growth
        run_trial(16'h0002);

        for (int t = 0; t < 20; t++) begin
            for (int l = 0; l < `LINK_COUNT; l++) begin
                draw_bits(`WEIGHT_W, v);
                ref_weight[l] = (v[1:0] == 2'd0) ? 2'd1 : v[1:0];
            end
            draw_bits(`PU_COUNT, v);
            run_trial(v[`PU_COUNT-1:0]);
        end

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, u_decoding_graph.u_props.fail_count);
        if (error_count == 0 && u_decoding_graph.u_props.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // each trial gets 9 rounds of 40 cycles
    initial begin
        #((NUM_TRIALS * 9 * MAX_BUSY + RESET_CYCLES) * 8);
        $display("watchdog expired, the stimulus did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule
